// ==== design/taint_mul_consts.svh ====
/*
 * Taint-tracking multiplier constants
 * Operand width and queue depths shared by the package and the RTL
 */

`ifndef TAINT_MUL_CONSTS_SVH
`define TAINT_MUL_CONSTS_SVH

// Operand width, product is twice this
`define MUL_WIDTH 8

// Request slots, equal to the requester's starting credits
`define REQ_DEPTH 2

// Result FIFO entries
`define RES_DEPTH 2

// Credits the consumer grants out of reset
`define RES_CREDITS 2

`endif

// ==== design/taint_mul_pkg.sv ====
/*
 * Taint-tracking multiplier types
 * Request and result words plus the sequencer state encoding
 */

`default_nettype none

`include "taint_mul_consts.svh"

package taint_mul_pkg;

    // Request word, each operand with its own taint bit
    typedef struct packed {
        logic [`MUL_WIDTH-1:0] multiplier;
        logic                  multiplier_t;
        logic [`MUL_WIDTH-1:0] multiplicand;
        logic                  multiplicand_t;
    } mul_req_t;

    // Finished product and its taint
    typedef struct packed {
        logic [2*`MUL_WIDTH-1:0] product;
        logic                    product_t;
    } mul_res_t;

    // Sequencer FSM states
    typedef enum logic [2:0] {
        IDLE  = 3'd0,
        LOAD  = 3'd1,
        ADD   = 3'd2,
        SHIFT = 3'd3,
        DONE  = 3'd4
    } seq_state_t;

endpackage

`default_nettype wire

// ==== design/mul_ctrl_if.sv ====
/*
 * Sequencer to datapath control bundle
 * Register controls with their taints, load operands and datapath status
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

interface mul_ctrl_if;
    import taint_mul_pkg::*;

    // Register controls, each paired with its taint
    logic     mdld;
    logic     mdld_t;
    logic     mrld;
    logic     mrld_t;
    logic     rsclear;
    logic     rsclear_t;
    logic     rsload;
    logic     rsload_t;
    logic     rsshr;
    logic     rsshr_t;

    // Operands presented during LOAD
    mul_req_t ld_ops;

    // Datapath status back to the sequencer
    logic                    mr_lsb;
    logic [2*`MUL_WIDTH-1:0] product;
    logic                    product_t;

    modport seq (
        output mdld, mdld_t, mrld, mrld_t, rsclear, rsclear_t,
        output rsload, rsload_t, rsshr, rsshr_t, ld_ops,
        input  mr_lsb, product, product_t
    );

    modport dp (
        input  mdld, mdld_t, mrld, mrld_t, rsclear, rsclear_t,
        input  rsload, rsload_t, rsshr, rsshr_t, ld_ops,
        output mr_lsb, product, product_t
    );

endinterface

`default_nettype wire

// ==== design/mul_sequencer.sv ====
/*
 * Multiplier sequencer
 * Queues requests and steps the datapath through load, add and shift
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module mul_sequencer (
    input  wire                      clk,
    input  wire                      arst_n,
    input  wire                      req_valid,
    input  wire taint_mul_pkg::mul_req_t req,
    input  wire                      res_full,
    output logic                     req_credit,
    output logic                     res_push,
    output taint_mul_pkg::mul_res_t  res,
    mul_ctrl_if.seq                  ctrl
);
    import taint_mul_pkg::*;

    localparam int PTR_W = $clog2(`REQ_DEPTH);
    localparam int CNT_W = $clog2(`REQ_DEPTH + 1);
    localparam int BIT_W = $clog2(`MUL_WIDTH);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`REQ_DEPTH - 1);
    localparam logic [BIT_W-1:0] LAST_BIT = BIT_W'(`MUL_WIDTH - 1);

    mul_req_t         fifo_mem [`REQ_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] fifo_cnt;
    logic             pop;
    mul_req_t         head;

    seq_state_t       state;
    seq_state_t       state_nxt;
    logic [BIT_W-1:0] bit_cnt;
    logic             op_mr_t;
    logic             op_t;

    // ========================================
    // Request FIFO
    // ========================================
    assign pop  = (state == LOAD);
    assign head = fifo_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (req_valid) begin
            fifo_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (req_valid) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({req_valid, pop})
                2'b10:   fifo_cnt <= fifo_cnt + 1'b1;
                2'b01:   fifo_cnt <= fifo_cnt - 1'b1;
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    // ========================================
    // FSM and bit counter
    // ========================================
    always_comb begin
        state_nxt = state;
        case (state)
            IDLE:  if (fifo_cnt != '0 && !res_full) state_nxt = LOAD;
            LOAD:  state_nxt = ADD;
            ADD:   state_nxt = SHIFT;
            SHIFT: state_nxt = (bit_cnt == LAST_BIT) ? DONE : ADD;
            DONE:  state_nxt = IDLE;
            default: state_nxt = IDLE;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= IDLE;
            bit_cnt <= '0;
            op_mr_t <= 1'b0;
            op_t    <= 1'b0;
        end else begin
            state <= state_nxt;
            if (state == LOAD) begin
                bit_cnt <= '0;
                // Keep the operand taints for the add and shift phases
                op_mr_t <= head.multiplier_t;
                op_t    <= head.multiplier_t | head.multiplicand_t;
            end else if (state == SHIFT) begin
                bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    // Datapath controls decode straight from the state
    assign ctrl.ld_ops    = head;
    assign ctrl.mdld      = (state == LOAD);
    assign ctrl.mdld_t    = (state == LOAD) & head.multiplicand_t;
    assign ctrl.mrld      = (state == LOAD);
    assign ctrl.mrld_t    = (state == LOAD) & head.multiplier_t;
    assign ctrl.rsclear   = (state == LOAD);
    assign ctrl.rsclear_t = (state == LOAD) & (head.multiplier_t | head.multiplicand_t);
    // Add decision is steered by the multiplier bit
    assign ctrl.rsload    = (state == ADD) & ctrl.mr_lsb;
    assign ctrl.rsload_t  = (state == ADD) & op_mr_t;
    assign ctrl.rsshr     = (state == SHIFT);
    assign ctrl.rsshr_t   = (state == SHIFT) & op_t;

    // One credit back per multiply started
    assign req_credit    = pop;
    assign res_push      = (state == DONE);
    assign res.product   = ctrl.product;
    assign res.product_t = ctrl.product_t;

endmodule

`default_nettype wire

// ==== design/mul_datapath.sv ====
/*
 * Shift-add multiplier datapath
 * Multiplicand, multiplier and running-sum registers with taint bits
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module mul_datapath (
    input wire      clk,
    input wire      arst_n,
    mul_ctrl_if.dp  ctrl
);
    import taint_mul_pkg::*;

    localparam int W = `MUL_WIDTH;

    // Sum is one bit wider than the product to catch the add carry
    logic [2*W:0] md_reg;
    logic         md_t;
    logic [W-1:0] mr_reg;
    logic         mr_t;
    logic [2*W:0] rs_reg;
    logic         rs_t;

    // ========================================
    // Data registers
    // ========================================
    always_ff @(posedge clk) begin
        // Multiplicand sits in the upper half
        if (ctrl.mdld) begin
            md_reg <= {1'b0, ctrl.ld_ops.multiplicand, {W{1'b0}}};
        end

        if (ctrl.mrld) begin
            mr_reg <= ctrl.ld_ops.multiplier;
        end else if (ctrl.rsshr) begin
            mr_reg <= {1'b0, mr_reg[W-1:1]};
        end

        if (ctrl.rsclear) begin
            rs_reg <= '0;
        end else if (ctrl.rsload) begin
            rs_reg <= rs_reg + md_reg;
        end else if (ctrl.rsshr) begin
            // Unsigned, so a zero comes in at the top
            rs_reg <= {1'b0, rs_reg[2*W:1]};
        end
    end

    // ========================================
    // Taint registers
    // ========================================
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            md_t <= 1'b0;
            mr_t <= 1'b0;
            rs_t <= 1'b0;
        end else begin
            md_t <= ctrl.mdld ? ctrl.mdld_t : (md_t | ctrl.mdld_t);

            if (ctrl.mrld) begin
                mr_t <= ctrl.mrld_t;
            end else if (ctrl.rsshr) begin
                mr_t <= mr_t | ctrl.rsshr_t;
            end

            // Clear drops the old taint, the control taint still applies
            if (ctrl.rsclear) begin
                rs_t <= ctrl.rsclear_t;
            end else if (ctrl.rsload) begin
                rs_t <= rs_t | ctrl.rsload_t | md_t | mr_t;
            end else if (ctrl.rsshr) begin
                rs_t <= rs_t | ctrl.rsshr_t;
            end else begin
                // A skipped add was still decided by a tainted bit
                rs_t <= rs_t | ctrl.rsload_t;
            end
        end
    end

    assign ctrl.mr_lsb    = mr_reg[0];
    assign ctrl.product   = rs_reg[2*W-1:0];
    assign ctrl.product_t = rs_t;

endmodule

`default_nettype wire

// ==== design/mul_result_buffer.sv ====
/*
 * Result buffer
 * Product FIFO that releases entries against consumer credits
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module mul_result_buffer (
    input  wire                          clk,
    input  wire                          arst_n,
    input  wire                          res_push,
    input  wire taint_mul_pkg::mul_res_t res,
    input  wire                          res_credit,
    output logic                         res_full,
    output logic                         res_valid,
    output logic [2*`MUL_WIDTH-1:0]      product,
    output logic                         product_t
);
    import taint_mul_pkg::*;

    localparam int PTR_W = $clog2(`RES_DEPTH);
    localparam int CNT_W = $clog2(`RES_DEPTH + 1);
    localparam int CRD_W = $clog2(`RES_CREDITS + 1);
    localparam logic [PTR_W-1:0] LAST_PTR = PTR_W'(`RES_DEPTH - 1);

    mul_res_t         buf_mem [`RES_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] buf_cnt;
    logic [CRD_W-1:0] credit_cnt;

    // ========================================
    // Storage
    // ========================================
    always_ff @(posedge clk) begin
        if (res_push) begin
            buf_mem[wr_ptr] <= res;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            buf_cnt    <= '0;
            credit_cnt <= CRD_W'(`RES_CREDITS);
        end else begin
            if (res_push) begin
                wr_ptr <= (wr_ptr == LAST_PTR) ? '0 : wr_ptr + 1'b1;
            end
            if (res_valid) begin
                rd_ptr <= (rd_ptr == LAST_PTR) ? '0 : rd_ptr + 1'b1;
            end
            case ({res_push, res_valid})
                2'b10:   buf_cnt <= buf_cnt + 1'b1;
                2'b01:   buf_cnt <= buf_cnt - 1'b1;
                default: buf_cnt <= buf_cnt;
            endcase
            // Spend one per result, regain one per credit pulse
            case ({res_credit, res_valid})
                2'b10:   credit_cnt <= credit_cnt + 1'b1;
                2'b01:   credit_cnt <= credit_cnt - 1'b1;
                default: credit_cnt <= credit_cnt;
            endcase
        end
    end

    // Oldest entry goes out whenever credit is held
    assign res_valid = (buf_cnt != '0) && (credit_cnt != '0);
    assign product   = buf_mem[rd_ptr].product;
    assign product_t = buf_mem[rd_ptr].product_t;
    assign res_full  = (buf_cnt == CNT_W'(`RES_DEPTH));

endmodule

`default_nettype wire

// ==== design/taint_mul_top.sv ====
/*
 * Taint-tracking sequential multiplier
 * Request queue, shift-add datapath and credited result buffer
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module taint_mul_top (
    input  wire                          clk,
    input  wire                          arst_n,
    // Request side
    input  wire                          req_valid,
    input  wire [`MUL_WIDTH-1:0]         multiplier,
    input  wire                          multiplier_t,
    input  wire [`MUL_WIDTH-1:0]         multiplicand,
    input  wire                          multiplicand_t,
    output wire                          req_credit,
    // Result side
    output wire                          res_valid,
    output wire [2*`MUL_WIDTH-1:0]       product,
    output wire                          product_t,
    input  wire                          res_credit
);
    import taint_mul_pkg::*;

    mul_req_t req;
    mul_res_t res;
    logic     res_push;
    logic     res_full;

    mul_ctrl_if ctrl ();

    assign req.multiplier     = multiplier;
    assign req.multiplier_t   = multiplier_t;
    assign req.multiplicand   = multiplicand;
    assign req.multiplicand_t = multiplicand_t;

    mul_sequencer u_seq (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req        (req),
        .res_full   (res_full),
        .req_credit (req_credit),
        .res_push   (res_push),
        .res        (res),
        .ctrl       (ctrl.seq)
    );

    mul_datapath u_dp (
        .clk    (clk),
        .arst_n (arst_n),
        .ctrl   (ctrl.dp)
    );

    mul_result_buffer u_resbuf (
        .clk        (clk),
        .arst_n     (arst_n),
        .res_push   (res_push),
        .res        (res),
        .res_credit (res_credit),
        .res_full   (res_full),
        .res_valid  (res_valid),
        .product    (product),
        .product_t  (product_t)
    );

endmodule

`default_nettype wire

// ==== dv/taint_mul_asserts.sv ====
/*
 * Taint multiplier protocol checks
 * Credit and valid rules at the top-level ports
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module taint_mul_asserts (
    input wire                             clk,
    input wire                             arst_n,
    input wire                             req_valid,
    input wire                             req_credit,
    input wire                             res_valid,
    input wire                             res_credit,
    input wire taint_mul_pkg::seq_state_t  seq_state
);
    import taint_mul_pkg::*;

    // Requests accepted but not yet credited back
    logic [3:0] req_pending;
    // Result credits the DUT currently holds
    logic [3:0] res_held;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            req_pending <= '0;
            res_held    <= 4'(`RES_CREDITS);
        end else begin
            req_pending <= req_pending + {3'b0, req_valid} - {3'b0, req_credit};
            res_held    <= res_held + {3'b0, res_credit} - {3'b0, res_valid};
        end
    end

    // ========================================
    // Result side
    // ========================================
    res_needs_credit: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> res_held != 4'd0)
        else $error("Result sent with no credit held");

    // ========================================
    // Request side
    // ========================================
    req_credit_owed: assert property (@(posedge clk) disable iff (!arst_n)
        req_credit |-> req_pending != 4'd0)
        else $error("Request credit returned with no request accepted");

    // One LOAD cycle, an ADD and a SHIFT per bit, then DONE
    req_credit_to_done: assert property (@(posedge clk) disable iff (!arst_n)
        req_credit |-> ##(2*`MUL_WIDTH+1) seq_state == DONE)
        else $error("Multiply did not reach its done state on time");

    req_no_overrun: assert property (@(posedge clk) disable iff (!arst_n)
        req_valid && !req_credit |-> req_pending < 4'(`REQ_DEPTH))
        else $error("Request sent with the request FIFO full");

    // Outputs stay quiet while reset is held
    quiet_in_reset: assert property (@(posedge clk)
        !arst_n |-> !req_credit && !res_valid)
        else $error("Output pulse during reset");

endmodule

`default_nettype wire

// ==== dv/taint_mul_tb.sv ====
/*
 * Taint multiplier testbench
 * Directed and random requests, credit-driven consumer, result checks
 */

`timescale 1ns/10ps
`default_nettype none

`include "taint_mul_consts.svh"

module taint_mul_tb;

    localparam int W               = `MUL_WIDTH;
    localparam int N_RANDOM        = 40;
    localparam int N_BACKPRESSURE  = `RES_CREDITS + `RES_DEPTH + `REQ_DEPTH;
    localparam int N_REQ           = 6 + 2 * W + 10 + N_RANDOM + N_BACKPRESSURE;
    localparam int HOLD_CYCLES     = 200;
    localparam int WATCHDOG_CYCLES = N_REQ * (2 * W + 3) * 4 + HOLD_CYCLES + 1000;

    logic           clk;
    logic           arst_n;
    logic           req_valid;
    logic [W-1:0]   multiplier;
    logic           multiplier_t;
    logic [W-1:0]   multiplicand;
    logic           multiplicand_t;
    logic           req_credit;
    logic           res_valid;
    logic [2*W-1:0] product;
    logic           product_t;
    logic           res_credit;

    int             seed = 32'h3df86513;
    string          test_name = "reset";

    // Expected results in request order
    logic [2*W-1:0] exp_prod_mem [256];
    logic           exp_taint_mem [256];
    logic [7:0]     sent         = '0;
    logic [7:0]     res_idx      = '0;
    logic [7:0]     credits_back = '0;
    logic [2*W-1:0] exp_product;
    logic           exp_taint;

    // Consumer state
    logic           credit_pat [256];
    logic [7:0]     pat_idx     = '0;
    logic [3:0]     owed        = '0;
    logic           hold_credit = 1'b0;

    taint_mul_top uut (
        .clk            (clk),
        .arst_n         (arst_n),
        .req_valid      (req_valid),
        .multiplier     (multiplier),
        .multiplier_t   (multiplier_t),
        .multiplicand   (multiplicand),
        .multiplicand_t (multiplicand_t),
        .req_credit     (req_credit),
        .res_valid      (res_valid),
        .product        (product),
        .product_t      (product_t),
        .res_credit     (res_credit)
    );

    bind taint_mul_top taint_mul_asserts u_asserts (
        .clk        (clk),
        .arst_n     (arst_n),
        .req_valid  (req_valid),
        .req_credit (req_credit),
        .res_valid  (res_valid),
        .res_credit (res_credit),
        .seq_state  (u_seq.state)
    );

    // Unsigned product of the two operands
    function automatic logic [2*W-1:0] expected_product(input logic [W-1:0] a,
                                                        input logic [W-1:0] b);
        return {{W{1'b0}}, a} * {{W{1'b0}}, b};
    endfunction

    task automatic abort_run(input string line);
        $display("%s", line);
        $display("*** TEST FAILED ***");
        $fatal(1, "Simulation stopped on a failed check");
    endtask

    task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                   input logic [31:0] act_val);
        abort_run($sformatf("[ERROR] %s: expected %0h, actual %0h", name, exp_val, act_val));
    endtask

    // One request, sent only while a request credit is held
    task automatic send_request(input logic [W-1:0] mr, input logic mr_t,
                                input logic [W-1:0] md, input logic md_t);
        @(posedge clk);
        while ((sent - credits_back) >= 8'(`REQ_DEPTH)) begin
            req_valid <= 1'b0;
            @(posedge clk);
        end
        req_valid           <= 1'b1;
        multiplier          <= mr;
        multiplier_t        <= mr_t;
        multiplicand        <= md;
        multiplicand_t      <= md_t;
        exp_prod_mem[sent]  = expected_product(mr, md);
        exp_taint_mem[sent] = mr_t | md_t;
        sent                = sent + 8'd1;
    endtask

    task automatic stop_requests();
        @(posedge clk);
        req_valid <= 1'b0;
    endtask

    task automatic wait_results();
        stop_requests();
        while (res_idx != sent) begin
            @(posedge clk);
        end
    endtask

    // ========================================
    // Result checks
    // ========================================
    assign exp_product = exp_prod_mem[res_idx];
    assign exp_taint   = exp_taint_mem[res_idx];

    always @(posedge clk) begin
        if (res_valid) begin
            res_idx <= res_idx + 8'd1;
        end
        if (req_credit) begin
            credits_back <= credits_back + 8'd1;
        end
    end

    result_expected: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> res_idx < sent)
        else abort_run("Result returned with no request outstanding");

    product_value: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> product == exp_product)
        else report_mismatch({"product in ", test_name},
                             32'($sampled(exp_product)), 32'($sampled(product)));

    product_taint: assert property (@(posedge clk) disable iff (!arst_n)
        res_valid |-> product_t == exp_taint)
        else report_mismatch({"taint in ", test_name},
                             32'($sampled(exp_taint)), 32'($sampled(product_t)));

    // ========================================
    // Clock, watchdog and consumer
    // ========================================
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_run("Watchdog expired before all results came back");
    end

    // Returns one credit per result, at random times unless held
    initial begin : consumer
        logic pulse;
        res_credit = 1'b0;
        forever begin
            @(posedge clk);
            pulse = !hold_credit && (owed != 4'd0) && credit_pat[pat_idx];
            res_credit <= pulse;
            owed       <= owed + {3'b0, res_valid} - {3'b0, pulse};
            pat_idx    <= pat_idx + 8'd1;
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin : main_seq
        logic [31:0] rnd;
        logic [7:0]  base_res;
        logic [7:0]  base_crd;

        arst_n         = 1'b1;
        req_valid      = 1'b0;
        multiplier     = '0;
        multiplier_t   = 1'b0;
        multiplicand   = '0;
        multiplicand_t = 1'b0;
        for (int i = 0; i < 256; i++) begin
            rnd = $random(seed);
            credit_pat[i[7:0]] = rnd[0];
        end
        #1 arst_n = 1'b0;
        repeat (10) @(posedge clk);
        arst_n <= 1'b1;
        // Quiet period, outputs must stay low
        repeat (5) @(posedge clk);

        test_name = "corner operands";
        send_request('0, 1'b0, '0, 1'b0);
        send_request('0, 1'b1, '1, 1'b0);
        send_request('1, 1'b0, '0, 1'b1);
        send_request('1, 1'b1, '1, 1'b1);
        send_request('1, 1'b0, W'(1), 1'b0);
        send_request(W'(1), 1'b0, '1, 1'b0);
        for (int i = 0; i < W; i++) begin
            send_request(W'(1) << i, i[0], '1, i[1]);
            send_request(W'(1) << i, 1'b0, W'(1) << (W - 1 - i), 1'b0);
        end
        wait_results();

        test_name = "taint combinations";
        for (int c = 0; c < 4; c++) begin
            rnd = $random(seed);
            send_request(rnd[W-1:0], c[1], rnd[2*W-1:W], c[0]);
        end
        // Tainted request then a clean one
        for (int c = 1; c < 4; c++) begin
            rnd = $random(seed);
            send_request(rnd[W-1:0], c[1], rnd[2*W-1:W], c[0]);
            send_request(rnd[2*W-1:W], 1'b0, rnd[W-1:0], 1'b0);
        end
        wait_results();

        test_name = "random operands";
        for (int n = 0; n < N_RANDOM; n++) begin
            rnd = $random(seed);
            send_request(rnd[W-1:0], rnd[2*W], rnd[2*W-1:W], rnd[2*W+1]);
        end
        wait_results();

        test_name = "result back-pressure";
        while (owed != 4'd0) begin
            @(posedge clk);
        end
        hold_credit <= 1'b1;
        base_res = res_idx;
        base_crd = credits_back;
        for (int n = 0; n < N_BACKPRESSURE; n++) begin
            rnd = $random(seed);
            send_request(rnd[W-1:0], rnd[2*W], rnd[2*W-1:W], rnd[2*W+1]);
        end
        stop_requests();
        repeat (HOLD_CYCLES) @(posedge clk);
        assert (res_idx - base_res == 8'(`RES_CREDITS))
            else report_mismatch("results released without credit",
                                 32'(`RES_CREDITS), 32'(res_idx - base_res));
        // Sequencer stalls once the buffer is full
        assert (credits_back - base_crd == 8'(`RES_CREDITS + `RES_DEPTH))
            else report_mismatch("request credits under back-pressure",
                                 32'(`RES_CREDITS + `RES_DEPTH), 32'(credits_back - base_crd));
        hold_credit <= 1'b0;
        wait_results();

        test_name = "request credits";
        repeat (10) @(posedge clk);
        assert (credits_back == sent)
            else report_mismatch(test_name, 32'(sent), 32'(credits_back));

        $display("*** TEST PASSED ***");
        $finish;
    end

endmodule

`default_nettype wire

// ==== sources.f ====
+incdir+design
design/taint_mul_pkg.sv
design/mul_ctrl_if.sv
design/mul_sequencer.sv
design/mul_datapath.sv
design/mul_result_buffer.sv
design/taint_mul_top.sv
dv/taint_mul_asserts.sv
dv/taint_mul_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the taint multiplier testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module taint_mul_tb \
    -f sources.f \
    -o sim_taint_mul

# The simulator exits nonzero on a fatal check, the log decides the verdict
./obj_dir/sim_taint_mul > sim.log 2>&1 || true
cat sim.log

if grep -qF '*** TEST FAILED ***' sim.log; then
    echo "Simulation failed"
    exit 1
fi

if ! grep -qF '*** TEST PASSED ***' sim.log; then
    echo "Simulation ended without a verdict"
    exit 1
fi

echo "Simulation passed"
